// ==== source/ksBusPkg.sv ====
`default_nettype none

package ksBusPkg;

   ////////////////////////////////////////
   // Bus word

   localparam int busWidth = 36;          // KS10 word

   // Shared by address and data
   typedef logic [busWidth-1:0] busWord;

   ////////////////////////////////////////
   // Address flags

   // Top four bits of an address word qualify the cycle
   localparam int flagPhysical   = 35;    // Physical reference
   localparam int flagIoCycle    = 34;    // I/O space, not memory
   localparam int flagWriteCycle = 33;    // Write when set, read when clear
   localparam int flagWruCycle   = 32;    // Who-are-you poll

   ////////////////////////////////////////
   // I/O address fields

   // Adapter number inside an I/O address
   localparam int devFieldLsb   = 18;
   localparam int devFieldWidth = 2;      // Up to four adapters

   // Register index, bottom of the address
   localparam int regFieldWidth = 3;

   // Memory cycles use the low bits as the word index,
   // width set by the memory itself

endpackage : ksBusPkg

`default_nettype wire

// ==== source/ksDevicePkg.sv ====
`default_nettype none

package ksDevicePkg;

   ////////////////////////////////////////
   // Device population

   // Unibus adapters on the backplane
   localparam int numAdapters = 4;

   // Register file size in each adapter
   localparam int adapterRegs = 8;       // Matches the 3-bit register index

   ////////////////////////////////////////
   // Memory

   // Word address bits, 1K words by default
   localparam int defaultMemAddrBits = 10;

endpackage : ksDevicePkg

`default_nettype wire

// ==== source/busArbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module busArbiter
(
   // CPU master
   input  wire logic                                cpuReq,
   input  wire ksBusPkg::busWord                    cpuAddr,
   input  wire ksBusPkg::busWord                    cpuWrData,
   output logic                                     cpuAck,
   output ksBusPkg::busWord                         cpuRdData,
   // Console master
   input  wire logic                                cslReq,
   input  wire ksBusPkg::busWord                    cslAddr,
   input  wire ksBusPkg::busWord                    cslWrData,
   output logic                                     cslGrantAck,
   output ksBusPkg::busWord                         cslRdDataOut,
   // Adapter masters (DMA)
   input  wire logic [ksDevicePkg::numAdapters-1:0] ubaReq,
   input  wire ksBusPkg::busWord                    ubaAddr [ksDevicePkg::numAdapters],
   input  wire ksBusPkg::busWord                    ubaData [ksDevicePkg::numAdapters],
   output logic [ksDevicePkg::numAdapters-1:0]      ubaAck,
   output ksBusPkg::busWord                         ubaDataOut, // Write data or DMA read data
   // Memory slave
   output logic                                     memReq,
   output ksBusPkg::busWord                         memWrData,
   input  wire logic                                memAck,
   input  wire ksBusPkg::busWord                    memRdData,
   // Adapter slaves
   output logic                                     ubaReqOut,
   input  wire logic [ksDevicePkg::numAdapters-1:0] ubaAckIn,
   input  wire ksBusPkg::busWord                    ubaRdData [ksDevicePkg::numAdapters],
   // Console slave
   output logic                                     cslReqOut,
   input  wire logic                                cslAck,
   input  wire ksBusPkg::busWord                    cslRdData,
   // Address to every slave
   output ksBusPkg::busWord                         busAddr
);

   import ksBusPkg::*;
   import ksDevicePkg::*;

   localparam int selWidth = $clog2(numAdapters);

   logic                slaveAck;    // Memory or some adapter answered
   busWord              slaveData;   // Data of the first one to answer
   logic [selWidth-1:0] ubaSel;      // Winning adapter request
   logic                cpuWru;      // Unanswered WRU gets a default ack

   assign cpuWru = cpuAddr[flagPhysical] & cpuAddr[flagIoCycle] & cpuAddr[flagWruCycle];

   ////////////////////////////////////////
   // Slave response chain

   // Memory first, then adapter 0 up to 3
   always_comb
   begin
      slaveAck  = 1'b0;
      slaveData = '0;
      for (int i = numAdapters - 1; i >= 0; i--)
      begin
         if (ubaAckIn[i])
         begin
            slaveAck  = 1'b1;
            slaveData = ubaRdData[i];
         end
      end
      if (memAck)
      begin
         slaveAck  = 1'b1;
         slaveData = memRdData;
      end
   end

   // Lowest numbered adapter wins
   always_comb
   begin
      ubaSel = '0;
      for (int i = numAdapters - 1; i >= 0; i--)
      begin
         if (ubaReq[i])
         begin
            ubaSel = selWidth'(i);
         end
      end
   end

   ////////////////////////////////////////
   // Grant and multiplexer

   always_comb
   begin
      cpuAck       = 1'b0;
      cpuRdData    = '0;
      cslGrantAck  = 1'b0;
      cslRdDataOut = '0;
      ubaAck       = '0;
      memReq       = 1'b0;
      ubaReqOut    = 1'b0;
      cslReqOut    = 1'b0;
      busAddr      = '0;
      memWrData    = '0;
      ubaDataOut   = '0;

      // Console, top priority; memory or adapters
      if (cslReq)
      begin
         memReq     = 1'b1;
         ubaReqOut  = 1'b1;
         busAddr    = cslAddr;
         memWrData  = cslWrData;
         ubaDataOut = cslWrData;
         if (slaveAck)
         begin
            cslGrantAck  = 1'b1;
            cslRdDataOut = slaveData;
         end
      end
      // Adapter DMA reaches memory only
      else if (|ubaReq)
      begin
         memReq     = 1'b1;
         busAddr    = ubaAddr[ubaSel];
         memWrData  = ubaData[ubaSel];
         ubaDataOut = memRdData;              // Read data back to the adapter
         ubaAck[ubaSel] = memAck;
      end
      // CPU last; memory, adapters or console
      else if (cpuReq)
      begin
         memReq     = 1'b1;
         ubaReqOut  = 1'b1;
         cslReqOut  = 1'b1;
         busAddr    = cpuAddr;
         memWrData  = cpuWrData;
         ubaDataOut = cpuWrData;
         if (slaveAck)
         begin
            cpuAck    = 1'b1;
            cpuRdData = slaveData;
         end
         else if (cslAck)
         begin
            cpuAck    = 1'b1;
            cpuRdData = cslRdData;
         end
         else if (cpuWru)
         begin
            cpuAck    = 1'b1;                 // Nobody home, answer zero
            cpuRdData = '0;
         end
      end
   end

endmodule : busArbiter

`default_nettype wire

// ==== source/memoryController.sv ====
`timescale 1ns/100ps
`default_nettype none

module memoryController
#(
   parameter int memAddrBits = ksDevicePkg::defaultMemAddrBits
)
(
   input  wire logic             clk,
   input  wire logic             rstN,
   input  wire logic             memReq,      // Some master owns the bus
   input  wire ksBusPkg::busWord busAddr,
   input  wire ksBusPkg::busWord memWrData,
   output logic                  memAck,
   output ksBusPkg::busWord      memRdData
);

   import ksBusPkg::*;

   localparam int memWords = 2 ** memAddrBits;

   busWord                 memArray [memWords];   // Main memory
   logic [memAddrBits-1:0] wordIdx;
   logic                   memSel;                // Memory cycle on the bus
   logic                   memWrite;
   logic                   ackPulse;

   ////////////////////////////////////////
   // Decode

   // Low bits pick the word
   assign wordIdx = busAddr[memAddrBits-1:0];

   // I/O cycles belong to the adapters or the console
   assign memSel   = memReq & ~busAddr[flagIoCycle];
   assign memWrite = busAddr[flagWriteCycle];

   ////////////////////////////////////////
   // Acknowledge

   // Pulse one cycle after the request, then rest a cycle
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         ackPulse <= 1'b0;
      end
      else
      begin
         ackPulse <= memSel & ~ackPulse;
      end
   end

   // A higher priority master may take the bus in the ack cycle;
   // the pulse then serves whatever memory cycle is on the bus
   assign memAck = ackPulse & memSel;

   ////////////////////////////////////////
   // Array

   // Read follows the live address during the ack
   assign memRdData = memArray[wordIdx];

   always_ff @(posedge clk)
   begin
      if (memAck & memWrite)
      begin
         memArray[wordIdx] <= memWrData;   // Write at the ack edge
      end
   end

endmodule : memoryController

`default_nettype wire

// ==== source/unibusAdapter.sv ====
`timescale 1ns/100ps
`default_nettype none

module unibusAdapter
#(
   parameter int adapterNum = 0
)
(
   input  wire logic             clk,
   input  wire logic             rstN,
   // Slave side
   input  wire logic             ubaReqOut,   // I/O cycle may be for us
   input  wire ksBusPkg::busWord busAddr,
   input  wire ksBusPkg::busWord ubaWrData,   // Also memory data on a DMA ack
   output logic                  ubaAckOut,
   output ksBusPkg::busWord      ubaRdData,
   // Master side
   input  wire logic             ubaGrantAck,
   output logic                  ubaReq,
   output ksBusPkg::busWord      ubaAddr,
   output ksBusPkg::busWord      ubaData,
   // DMA request from the device
   input  wire logic             dmaStart,
   input  wire ksBusPkg::busWord dmaAddr,
   input  wire ksBusPkg::busWord dmaWrData,
   input  wire logic             dmaWrite,
   output ksBusPkg::busWord      dmaRdData,
   output logic                  dmaDone
);

   import ksBusPkg::*;
   import ksDevicePkg::*;

   busWord                   regFile [adapterRegs];   // Device registers
   logic [regFieldWidth-1:0] regIdx;
   logic                     devSel;
   logic                     ackPulse;
   logic                     dmaPending;               // Request out on the bus
   logic                     dmaAccept;
   busWord                   dmaAddrReg;
   busWord                   dmaDataReg;
   logic                     dmaWriteReg;

   ////////////////////////////////////////
   // Slave side

   assign regIdx = busAddr[regFieldWidth-1:0];

   // Our number, not a WRU poll
   assign devSel = ubaReqOut & busAddr[flagIoCycle] & ~busAddr[flagWruCycle] &
                   (busAddr[devFieldLsb +: devFieldWidth] == devFieldWidth'(adapterNum));

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         ackPulse <= 1'b0;
      end
      else
      begin
         ackPulse <= devSel & ~ackPulse;   // One cycle later, one cycle long
      end
   end

   assign ubaAckOut = ackPulse & devSel;
   assign ubaRdData = regFile[regIdx];

   always_ff @(posedge clk)
   begin
      if (ubaAckOut & busAddr[flagWriteCycle])
      begin
         regFile[regIdx] <= ubaWrData;
      end
   end

   ////////////////////////////////////////
   // DMA master

   // New start ignored while one is pending
   assign dmaAccept = dmaStart & ~dmaPending;

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         dmaPending <= 1'b0;
         dmaDone    <= 1'b0;
      end
      else
      begin
         dmaDone <= dmaPending & ubaGrantAck;
         if (dmaPending & ubaGrantAck)
         begin
            dmaPending <= 1'b0;               // Drop the request after the ack
         end
         else if (dmaAccept)
         begin
            dmaPending <= 1'b1;
         end
      end
   end

   // Payload latches
   always_ff @(posedge clk)
   begin
      if (dmaAccept)
      begin
         dmaAddrReg  <= dmaAddr;
         dmaDataReg  <= dmaWrData;
         dmaWriteReg <= dmaWrite;
      end
      if (dmaPending & ubaGrantAck)
      begin
         dmaRdData <= ubaWrData;              // Memory word from the arbiter
      end
   end

   assign ubaReq  = dmaPending;
   assign ubaData = dmaDataReg;

   // Physical memory cycle, flags forced
   always_comb
   begin
      ubaAddr                 = dmaAddrReg;
      ubaAddr[flagPhysical]   = 1'b1;
      ubaAddr[flagIoCycle]    = 1'b0;
      ubaAddr[flagWriteCycle] = dmaWriteReg;
      ubaAddr[flagWruCycle]   = 1'b0;
   end

endmodule : unibusAdapter

`default_nettype wire

// ==== source/ksBusTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module ksBusTop
#(
   parameter int memAddrBits = ksDevicePkg::defaultMemAddrBits
)
(
   input  wire logic                                clk,
   input  wire logic                                rstN,
   // CPU master
   input  wire logic                                cpuReq,
   input  wire ksBusPkg::busWord                    cpuAddr,
   input  wire ksBusPkg::busWord                    cpuWrData,
   output wire logic                                cpuAck,
   output wire ksBusPkg::busWord                    cpuRdData,
   // Console master
   input  wire logic                                cslReq,
   input  wire ksBusPkg::busWord                    cslAddr,
   input  wire ksBusPkg::busWord                    cslMasterData,  // Console write data
   output wire logic                                cslGrantAck,
   output wire ksBusPkg::busWord                    cslRdDataOut,
   // Console slave
   output wire logic                                cslReqOut,
   output wire ksBusPkg::busWord                    cslWrData,
   input  wire logic                                cslAck,
   input  wire ksBusPkg::busWord                    cslRdData,
   output wire ksBusPkg::busWord                    busAddr,
   // DMA per adapter
   input  wire logic [ksDevicePkg::numAdapters-1:0] dmaStart,
   input  wire ksBusPkg::busWord                    dmaAddr [ksDevicePkg::numAdapters],
   input  wire ksBusPkg::busWord                    dmaWrData [ksDevicePkg::numAdapters],
   input  wire logic [ksDevicePkg::numAdapters-1:0] dmaWrite,
   output wire ksBusPkg::busWord                    dmaRdData [ksDevicePkg::numAdapters],
   output wire logic [ksDevicePkg::numAdapters-1:0] dmaDone
);

   import ksBusPkg::*;
   import ksDevicePkg::*;

   wire logic                   memReq;
   wire busWord                 memWrData;
   wire logic                   memAck;
   wire busWord                 memRdData;
   wire logic                   ubaReqOut;
   wire busWord                 ubaDataOut;                // Shared adapter data
   wire logic [numAdapters-1:0] ubaReq;
   wire busWord                 ubaAddr [numAdapters];
   wire busWord                 ubaData [numAdapters];
   wire logic [numAdapters-1:0] ubaAck;                    // Grant ack to DMA master
   wire logic [numAdapters-1:0] ubaAckIn;                  // Slave ack from adapter
   wire busWord                 ubaRdData [numAdapters];

   // Console slave sees the same write data as memory
   assign cslWrData = memWrData;

   busArbiter i_busArbiter
   (
      .cpuReq(cpuReq), .cpuAddr(cpuAddr), .cpuWrData(cpuWrData),
      .cpuAck(cpuAck), .cpuRdData(cpuRdData),
      .cslReq(cslReq), .cslAddr(cslAddr), .cslWrData(cslMasterData),
      .cslGrantAck(cslGrantAck), .cslRdDataOut(cslRdDataOut),
      .ubaReq(ubaReq), .ubaAddr(ubaAddr), .ubaData(ubaData),
      .ubaAck(ubaAck), .ubaDataOut(ubaDataOut),
      .memReq(memReq), .memWrData(memWrData), .memAck(memAck), .memRdData(memRdData),
      .ubaReqOut(ubaReqOut), .ubaAckIn(ubaAckIn), .ubaRdData(ubaRdData),
      .cslReqOut(cslReqOut), .cslAck(cslAck), .cslRdData(cslRdData),
      .busAddr(busAddr)
   );

   memoryController #(.memAddrBits(memAddrBits)) i_memoryController
   (
      .clk(clk), .rstN(rstN), .memReq(memReq), .busAddr(busAddr),
      .memWrData(memWrData), .memAck(memAck), .memRdData(memRdData)
   );

   ////////////////////////////////////////
   // Adapters, numbered by position

   for (genvar i = 0; i < numAdapters; i++)
   begin : gAdapter
      unibusAdapter #(.adapterNum(i)) i_unibusAdapter
      (
         .clk(clk), .rstN(rstN),
         .ubaReqOut(ubaReqOut), .busAddr(busAddr), .ubaWrData(ubaDataOut),
         .ubaAckOut(ubaAckIn[i]), .ubaRdData(ubaRdData[i]),
         .ubaGrantAck(ubaAck[i]), .ubaReq(ubaReq[i]),
         .ubaAddr(ubaAddr[i]), .ubaData(ubaData[i]),
         .dmaStart(dmaStart[i]), .dmaAddr(dmaAddr[i]), .dmaWrData(dmaWrData[i]),
         .dmaWrite(dmaWrite[i]), .dmaRdData(dmaRdData[i]), .dmaDone(dmaDone[i])
      );
   end

endmodule : ksBusTop

`default_nettype wire

// ==== verification/busArbiter_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module busArbiterAsserts
(
   input wire logic                                clk,
   input wire logic                                rstN,
   input wire logic                                cpuReq,
   input wire logic                                cpuAck,
   input wire logic                                cslReq,
   input wire logic                                cslGrantAck,
   input wire logic [ksDevicePkg::numAdapters-1:0] ubaReq,
   input wire logic [ksDevicePkg::numAdapters-1:0] ubaAck,
   input wire logic                                memReq
);

   logic violation = 1'b0;                 // Set by any failed rule

   // One master answered at a time
   assert property (@(posedge clk) disable iff (!rstN) $onehot0({cpuAck, cslGrantAck, ubaAck}))
      else
      begin
         $error("More than one master acknowledged");
         violation = 1'b1;
      end

   // Ack only to a requester
   assert property (@(posedge clk) disable iff (!rstN) cpuAck |-> cpuReq)
      else
      begin
         $error("CPU ack without request");
         violation = 1'b1;
      end
   assert property (@(posedge clk) disable iff (!rstN) cslGrantAck |-> cslReq)
      else
      begin
         $error("Console ack without request");
         violation = 1'b1;
      end
   assert property (@(posedge clk) disable iff (!rstN) (ubaAck & ~ubaReq) == '0)
      else
      begin
         $error("Adapter ack without request");
         violation = 1'b1;
      end

   // Every master can reach memory
   assert property (@(posedge clk) disable iff (!rstN) (cpuReq | cslReq | (|ubaReq)) |-> memReq)
      else
      begin
         $error("Request pending but memReq low");
         violation = 1'b1;
      end

endmodule : busArbiterAsserts

// Arbiter ports as seen in the top level, where the clock lives
bind ksBusTop busArbiterAsserts i_busArbiterAsserts
(
   .clk(clk), .rstN(rstN), .cpuReq(cpuReq), .cpuAck(cpuAck), .cslReq(cslReq),
   .cslGrantAck(cslGrantAck), .ubaReq(ubaReq), .ubaAck(ubaAck), .memReq(memReq)
);

`default_nettype wire

// ==== verification/ksBusTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ksBusTb;

   import ksBusPkg::*;
   import ksDevicePkg::*;

   localparam int memAddrBits = defaultMemAddrBits;
   localparam int testWords   = 64;        // Memory window under test
   localparam int memOps      = 150;
   localparam int ioOps       = 100;
   localparam int cslOps      = 20;
   localparam int wruOps      = 10;
   localparam int dmaRounds   = 30;
   localparam int prioOps     = 10;
   localparam int opCycles    = 3;         // Request, ack, idle
   localparam int cycleLimit  = 2 * (16 + opCycles * (testWords + memOps + ioOps + cslOps +
                                wruOps + numAdapters * adapterRegs) +
                                dmaRounds * (2 * numAdapters + 8) + prioOps * 8);

   logic clk, rstN;
   logic cpuReq, cpuAck, cslReq, cslGrantAck, cslReqOut, cslAck;
   busWord cpuAddr, cpuWrData, cpuRdData, cslAddr, cslMasterData, cslRdDataOut;
   busWord cslWrData, cslRdData, busAddr;
   logic [numAdapters-1:0] dmaStart, dmaWrite, dmaDone;
   busWord dmaAddr [numAdapters];
   busWord dmaWrData [numAdapters];
   busWord dmaRdData [numAdapters];

   // Reference model
   busWord memModel [testWords];
   busWord regModel [numAdapters][adapterRegs];
   busWord consoleWord;                    // Last word the console answered with
   busWord consoleAddr;                    // Bus address the console saw with it
   busWord consoleData;                    // Write data the console saw with it
   logic   cslAckQ;
   int     cycles;
   int     lastAckCycle;                   // Cycle of the latest CPU ack

   ksBusTop #(.memAddrBits(memAddrBits)) i_ksBusTop
   (
      .clk(clk), .rstN(rstN),
      .cpuReq(cpuReq), .cpuAddr(cpuAddr), .cpuWrData(cpuWrData),
      .cpuAck(cpuAck), .cpuRdData(cpuRdData),
      .cslReq(cslReq), .cslAddr(cslAddr), .cslMasterData(cslMasterData),
      .cslGrantAck(cslGrantAck), .cslRdDataOut(cslRdDataOut),
      .cslReqOut(cslReqOut), .cslWrData(cslWrData), .cslAck(cslAck),
      .cslRdData(cslRdData), .busAddr(busAddr),
      .dmaStart(dmaStart), .dmaAddr(dmaAddr), .dmaWrData(dmaWrData),
      .dmaWrite(dmaWrite), .dmaRdData(dmaRdData), .dmaDone(dmaDone)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;               // 4 ns period
   end

   ////////////////////////////////////////
   // Console responder and watchdog

   assign cslAck = cslAckQ & cslReqOut;    // Ack only while still asked

   always @(posedge clk)
   begin
      logic   sawReq;
      busWord seenAddr;
      busWord seenData;
      sawReq   = cslReqOut & ~cslAckQ;     // One cycle later, one cycle long
      seenAddr = busAddr;
      seenData = cslWrData;
      #1;
      if (sawReq)
      begin
         consoleWord = randWord();
         consoleAddr = seenAddr;
         consoleData = seenData;
         cslRdData   = consoleWord;
      end
      cslAckQ = sawReq;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= cycleLimit)
      begin
         $display("Timeout: the bus stopped answering after %0d cycles", cycles);
         $display("test failed");
         $fatal(1, "Run stopped by the watchdog");
      end
   end

   // Bound arbiter checker flags a broken grant rule here
   always @(i_ksBusTop.i_busArbiterAsserts.violation)
   begin
      assert (!i_ksBusTop.i_busArbiterAsserts.violation)
      else failPlain("An arbiter grant rule was broken, see the assertion error above");
   end

   ////////////////////////////////////////
   // Helpers

   function automatic busWord randWord();
      return busWord'({$urandom(), $urandom()});
   endfunction

   function automatic busWord memWord(int idx, logic write);
      busWord a = '0;
      a[flagPhysical]   = 1'b1;
      a[flagWriteCycle] = write;
      a[memAddrBits-1:0] = memAddrBits'(idx);
      return a;
   endfunction

   function automatic busWord ioWord(int dev, int regNum, logic write);
      busWord a = memWord(0, write);
      a[flagIoCycle] = 1'b1;
      a[devFieldLsb +: devFieldWidth] = devFieldWidth'(dev);
      a[regFieldWidth-1:0] = regFieldWidth'(regNum);
      return a;
   endfunction

   task automatic checkEq(string name, busWord expected, busWord actual);
      assert (expected === actual)
      else
      begin
         $display("** Error [%s] expected %h actual %h", name, expected, actual);
         $display("test failed");
         $fatal(1, "Value mismatch");
      end
   endtask

   task automatic failPlain(string what);
      $display("%s", what);
      $display("test failed");
      $fatal(1, "Protocol error");
   endtask

   // One CPU cycle; latency 0 means ack in the request cycle
   task automatic cpuAccess(busWord addr, busWord wrData, output busWord rdData,
                            output int latency);
      cpuAddr   = addr;
      cpuWrData = wrData;
      cpuReq    = 1'b1;
      latency   = 0;
      @(negedge clk);
      while (!cpuAck)
      begin
         latency++;
         @(negedge clk);
      end
      rdData       = cpuRdData;
      lastAckCycle = cycles;
      @(posedge clk);
      #1 cpuReq = 1'b0;
      cpuAddr = '0;
      @(posedge clk);                      // Idle cycle between accesses
      #1;
   endtask

   ////////////////////////////////////////
   // Tests

   task automatic cpuMemory();
      busWord rd, wd;
      int     lat, idx;
      for (int n = 0; n < testWords + memOps; n++)
      begin
         idx = (n < testWords) ? n : int'($urandom % testWords);   // Preload first
         if (n < testWords || $urandom % 2)
         begin
            wd = randWord();
            cpuAccess(memWord(idx, 1'b1), wd, rd, lat);
            memModel[idx] = wd;
         end
         else
         begin
            cpuAccess(memWord(idx, 1'b0), '0, rd, lat);
            checkEq("cpuMemory data", memModel[idx], rd);
         end
         checkEq("cpuMemory latency", 1, busWord'(lat));
      end
   endtask

   task automatic cpuIo();
      busWord rd, wd;
      int     lat, dev, r;
      for (int n = 0; n < numAdapters * adapterRegs + ioOps; n++)
      begin
         dev = (n < numAdapters * adapterRegs) ? n / adapterRegs : int'($urandom % numAdapters);
         r   = (n < numAdapters * adapterRegs) ? n % adapterRegs : int'($urandom % adapterRegs);
         if (n < numAdapters * adapterRegs || $urandom % 2)
         begin
            wd = randWord();
            cpuAccess(ioWord(dev, r, 1'b1), wd, rd, lat);
            regModel[dev][r] = wd;
         end
         else
         begin
            cpuAccess(ioWord(dev, r, 1'b0), '0, rd, lat);
            checkEq("cpuIo data", regModel[dev][r], rd);
         end
         checkEq("cpuIo latency", 1, busWord'(lat));
      end
   endtask

   // I/O with WRU but no physical flag, nobody but the console claims it
   task automatic cpuConsole();
      busWord rd, a, wd;
      int     lat;
      for (int n = 0; n < cslOps; n++)
      begin
         wd = randWord();
         a  = ioWord($urandom % numAdapters, $urandom % adapterRegs, 1'($urandom % 2));
         a[flagPhysical] = 1'b0;
         a[flagWruCycle] = 1'b1;
         cpuAccess(a, wd, rd, lat);
         checkEq("cpuConsole address", a, consoleAddr);
         checkEq("cpuConsole write data", wd, consoleData);
         checkEq("cpuConsole data", consoleWord, rd);
         checkEq("cpuConsole latency", 1, busWord'(lat));
      end
   endtask

   task automatic cpuWru();
      busWord rd, a;
      int     lat;
      for (int n = 0; n < wruOps; n++)
      begin
         a = ioWord($urandom % numAdapters, 0, 1'b0);
         a[flagWruCycle] = 1'b1;
         cpuAccess(a, '0, rd, lat);
         checkEq("cpuWru data", '0, rd);
         checkEq("cpuWru latency", 0, busWord'(lat));
      end
   endtask

   task automatic dma();
      busWord expDma [numAdapters];
      busWord rd;
      int     base, need, doneCount, lat, cpuIdx, idx;
      logic [numAdapters-1:0] mask;
      logic   cpuToo;
      for (int n = 0; n < dmaRounds; n++)
      begin
         base   = $urandom % testWords;
         mask   = numAdapters'(1 + $urandom % (2 ** numAdapters - 1));
         cpuToo = $urandom % 2;
         cpuIdx = (base + numAdapters + $urandom % (testWords - numAdapters)) % testWords;
         for (int i = 0; i < numAdapters; i++)
         begin
            if (mask[i])
            begin
               idx          = (base + i) % testWords;   // Distinct words per round
               dmaAddr[i]   = memWord(idx, 1'b0);
               dmaWrite[i]  = $urandom % 2;
               dmaWrData[i] = randWord();
               expDma[i]    = memModel[idx];            // Old word, also on a write
               if (dmaWrite[i])
               begin
                  memModel[idx] = dmaWrData[i];
               end
            end
         end
         dmaStart = mask;
         @(posedge clk);
         #1 dmaStart = '0;
         need      = $countones(mask);
         doneCount = 0;
         fork
            begin
               if (cpuToo)
               begin
                  cpuAccess(memWord(cpuIdx, 1'b0), '0, rd, lat);
                  checkEq("dma cpu data", memModel[cpuIdx], rd);
               end
            end
            begin
               while (doneCount < need)
               begin
                  @(negedge clk);
                  assert (!cpuAck)
                  else failPlain("CPU was acknowledged while a DMA was still pending");
                  for (int i = 0; i < numAdapters; i++)
                  begin
                     if (dmaDone[i])
                     begin
                        checkEq("dma data", expDma[i], dmaRdData[i]);
                        doneCount++;
                     end
                  end
               end
            end
         join
         @(posedge clk);
         #1;
      end
   endtask

   task automatic consolePriority();
      busWord rd;
      int     lat, cslIdx, cpuIdx, cslAckCycle;
      for (int n = 0; n < prioOps; n++)
      begin
         cslIdx  = $urandom % testWords;
         cpuIdx  = $urandom % testWords;
         cslAddr = memWord(cslIdx, 1'b0);
         cslReq  = 1'b1;
         fork
            begin
               @(negedge clk);
               while (!cslGrantAck)
               begin
                  @(negedge clk);
               end
               cslAckCycle = cycles;
               checkEq("consolePriority console data", memModel[cslIdx], cslRdDataOut);
               @(posedge clk);
               #1 cslReq = 1'b0;
            end
            cpuAccess(memWord(cpuIdx, 1'b0), '0, rd, lat);
         join
         assert (lastAckCycle > cslAckCycle)
         else failPlain("CPU was acknowledged before the console");
         checkEq("consolePriority cpu data", memModel[cpuIdx], rd);
      end
   endtask

   ////////////////////////////////////////
   // Main sequence

   initial
   begin
      void'($urandom(32'hc3e6));
      rstN = 1'b0;
      cpuReq = 1'b0;
      cpuAddr = '0;
      cpuWrData = '0;
      cslReq = 1'b0;
      cslAddr = '0;
      cslMasterData = '0;
      cslRdData = '0;
      cslAckQ = 1'b0;
      consoleWord = '0;
      consoleAddr = '0;
      consoleData = '0;
      cycles = 0;
      lastAckCycle = 0;
      dmaStart = '0;
      dmaWrite = '0;
      for (int i = 0; i < numAdapters; i++)
      begin
         dmaAddr[i]   = '0;
         dmaWrData[i] = '0;
      end
      repeat (16) @(posedge clk);
      #1 rstN = 1'b1;
      @(negedge clk);
      checkEq("reset acks", '0, busWord'({cpuAck, cslGrantAck, dmaDone}));
      @(posedge clk);
      #1;
      cpuMemory();
      cpuIo();
      cpuConsole();
      cpuWru();
      dma();
      consolePriority();
      $display("test passed");
      $finish;
   end

endmodule : ksBusTb

`default_nettype wire

// ==== compile.f ====
source/ksBusPkg.sv
source/ksDevicePkg.sv
source/busArbiter.sv
source/memoryController.sv
source/unibusAdapter.sv
source/ksBusTop.sv
verification/busArbiter_asserts.sv
verification/ksBusTb.sv

// ==== Bender.yml ====
package:
  name: ksBus

sources:
  - files:
      - source/ksBusPkg.sv
      - source/ksDevicePkg.sv
      - source/busArbiter.sv
      - source/memoryController.sv
      - source/unibusAdapter.sv
      - source/ksBusTop.sv
  - target: test
    files:
      - verification/busArbiter_asserts.sv
      - verification/ksBusTb.sv
